// File: logic/floo_mcast_pkg.sv
// Type definitions shared by every module of the multicast fork stage and imported by each of them
`default_nettype none

package floo_mcast_pkg;

  // ----------------------------------------------------------------------
  // Mesh coordinates
  // ----------------------------------------------------------------------

  // Column index inside a mesh of up to 8 columns
  typedef logic [2:0] x_coord_t;

  // Row index inside a mesh of up to 8 rows
  typedef logic [2:0] y_coord_t;

  // One position in the mesh
  // The same type is used for the router id, the source and the destination
  // When used as a multicast mask a set bit means the bit may take either value
  typedef struct packed {
    x_coord_t x;
    y_coord_t y;
  } xy_id_t;

  // ----------------------------------------------------------------------
  // Flit layout
  // ----------------------------------------------------------------------

  // Routing header with 18 bits in total
  // The destination together with the mask describes a rectangle of receivers
  typedef struct packed {
    xy_id_t dst_id;
    xy_id_t src_id;
    xy_id_t mask;
  } hdr_t;

  // Data word carried unchanged through the stage
  typedef logic [31:0] payload_t;

  // Full flit of 50 bits with the header in the upper bits
  typedef struct packed {
    hdr_t     hdr;
    payload_t payload;
  } flit_t;

  // ----------------------------------------------------------------------
  // Output ports
  // ----------------------------------------------------------------------

  // Port index of each output link of the router
  typedef enum logic [2:0] {
    Eject = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } route_dir_e;

  // Number of output ports, one per route_dir_e value
  localparam int unsigned NumRoutes = 5;

  // One bit per output port, indexed with route_dir_e
  typedef logic [NumRoutes-1:0] route_mask_t;

  // Fill level and credit counter
  // Four bits limit both the buffer depth and the credits per port to 15
  typedef logic [3:0] credit_cnt_t;

endpackage

`default_nettype wire

// File: logic/floo_mcast_in_buffer.sv
// Credit-based input FIFO of the fork stage, instantiated once per input link by the node
`default_nettype none

module floo_mcast_in_buffer #(
  // Number of entries, which is also the number of credits held upstream
  parameter int unsigned BufDepth = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Upstream link where a write is only allowed while the sender holds a credit
  input  logic                  valid_i,
  input  floo_mcast_pkg::flit_t flit_i,
  output logic                  credit_o,
  // Head of the FIFO as seen by the fork
  output logic                  head_valid_o,
  output floo_mcast_pkg::flit_t head_flit_o,
  input  logic                  pop_i
);

  import floo_mcast_pkg::*;

  // A single entry still needs one pointer bit
  localparam int unsigned PtrWidth = (BufDepth > 1) ? $clog2(BufDepth) : 1;

  typedef logic [PtrWidth-1:0] ptr_t;

  // Storage of the FIFO entries
  flit_t mem_q [BufDepth];

  ptr_t        wr_ptr_q, wr_ptr_d;
  ptr_t        rd_ptr_q, rd_ptr_d;
  credit_cnt_t fill_q;
  logic        full;
  logic        push;
  logic        credit_q;

  // ----------------------------------------------------------------------
  // Pointer and fill count update
  // ----------------------------------------------------------------------

  assign full = (fill_q == credit_cnt_t'(BufDepth));

  // Writes into a full FIFO are dropped
  assign push = valid_i && !full;

  // Both pointers wrap at the last entry since the depth need not be a power of two
  assign wr_ptr_d = (wr_ptr_q == ptr_t'(BufDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
  assign rd_ptr_d = (rd_ptr_q == ptr_t'(BufDepth - 1)) ? '0 : rd_ptr_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_d;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_d;
      end
      // Simultaneous push and pop leave the fill count as it is
      if (push && !pop_i) begin
        fill_q <= fill_q + 1'b1;
      end else if (!push && pop_i) begin
        fill_q <= fill_q - 1'b1;
      end
      // Each freed entry goes back upstream as one credit in the next cycle
      credit_q <= pop_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  // The head is visible right after the edge that wrote it
  assign head_valid_o = (fill_q != '0);
  assign head_flit_o  = mem_q[rd_ptr_q];
  assign credit_o     = credit_q;

  // A write into a full buffer means the sender used a credit it did not hold
  assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_i |-> !full)
    else $error("write into full input buffer, upstream credit protocol broken");

  // The fork must only pop what the buffer presents as head
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> head_valid_o)
    else $error("pop from empty input buffer");

endmodule

`default_nettype wire

// File: logic/floo_route_xymask.sv
// Combinational XY multicast route mask that the node applies to the head flit of its input buffer
`default_nettype none

module floo_route_xymask (
  // Only the header of the flit is looked at
  input  floo_mcast_pkg::flit_t       flit_i,
  // Position of this router in the mesh
  input  floo_mcast_pkg::xy_id_t      xy_id_i,
  // One bit per output port that must receive a copy
  output floo_mcast_pkg::route_mask_t route_sel_o
);

  import floo_mcast_pkg::*;

  // Under XY routing a flit first runs along its source row and turns into
  // the columns of its destinations afterwards
  // A multicast therefore spreads along the source row up to the furthest
  // destination column and then along each destination column up to the
  // furthest destination row

  xy_id_t dst_id;
  xy_id_t src_id;
  xy_id_t mask;

  // Corners of the destination rectangle
  xy_id_t dst_max;
  xy_id_t dst_min;

  // This router lies in a destination column or row
  logic x_match;
  logic y_match;

  // This router lies in the row where the flit was injected
  logic in_src_row;

  assign dst_id = flit_i.hdr.dst_id;
  assign src_id = flit_i.hdr.src_id;
  assign mask   = flit_i.hdr.mask;

  // ----------------------------------------------------------------------
  // Reach of the multicast
  // ----------------------------------------------------------------------

  // Forcing the masked bits high gives the largest coordinate in the set
  assign dst_max.x = dst_id.x | mask.x;
  assign dst_max.y = dst_id.y | mask.y;

  // Forcing them low gives the smallest one
  assign dst_min.x = dst_id.x & ~mask.x;
  assign dst_min.y = dst_id.y & ~mask.y;

  // Every unmasked bit of the coordinate has to agree with the destination
  assign x_match = &(mask.x | ~(xy_id_i.x ^ dst_id.x));
  assign y_match = &(mask.y | ~(xy_id_i.y ^ dst_id.y));

  assign in_src_row = (xy_id_i.y == src_id.y);

  // ----------------------------------------------------------------------
  // Port selection
  // ----------------------------------------------------------------------

  always_comb begin
    route_sel_o = '0;

    // The local endpoint is a receiver when both coordinates fall into the set
    if (x_match && y_match) begin
      route_sel_o[Eject] = 1'b1;
    end

    // Along the source row the flit keeps moving east while columns further
    // east still hold destinations, and the same holds towards the west
    if (in_src_row) begin
      if ((xy_id_i.x >= src_id.x) && (xy_id_i.x < dst_max.x)) begin
        route_sel_o[East] = 1'b1;
      end
      if ((xy_id_i.x <= src_id.x) && (xy_id_i.x > dst_min.x)) begin
        route_sel_o[West] = 1'b1;
      end
    end

    // Inside a destination column the flit leaves the source row towards
    // north and south as long as rows on that side still hold destinations
    if (x_match) begin
      if ((xy_id_i.y >= src_id.y) && (xy_id_i.y < dst_max.y)) begin
        route_sel_o[North] = 1'b1;
      end
      if ((xy_id_i.y <= src_id.y) && (xy_id_i.y > dst_min.y)) begin
        route_sel_o[South] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/floo_mcast_fork.sv
// Output side of the node that copies each head flit to its selected ports under per-port credits
`default_nettype none

module floo_mcast_fork #(
  // Credits each output port starts with after reset
  parameter int unsigned MaxCredits = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Head of the input buffer together with its route mask
  input  logic                        head_valid_i,
  input  floo_mcast_pkg::flit_t       head_flit_i,
  input  floo_mcast_pkg::route_mask_t route_sel_i,
  output logic                        pop_o,
  // Output links that share one flit bus
  output floo_mcast_pkg::route_mask_t valid_o,
  output floo_mcast_pkg::flit_t       flit_o,
  input  floo_mcast_pkg::route_mask_t credit_i
);

  import floo_mcast_pkg::*;

  typedef enum logic {
    FORK_IDLE,
    FORK_SEND
  } fork_state_e;

  fork_state_e state_q, state_d;

  // Ports that still owe a copy of the held flit
  route_mask_t pending_q, pending_d;

  // Flit that is currently being copied
  flit_t flit_q;

  // Credits left per output port
  credit_cnt_t [NumRoutes-1:0] cnt_q, cnt_d;

  route_mask_t credit_avail;
  route_mask_t send;
  logic        load;

  // ----------------------------------------------------------------------
  // Fork FSM
  // ----------------------------------------------------------------------

  always_comb begin
    state_d   = state_q;
    pending_d = pending_q;
    send      = '0;
    load      = 1'b0;

    unique case (state_q)
      FORK_IDLE: begin
        load = head_valid_i;
      end
      FORK_SEND: begin
        // Every pending port with a credit gets its copy in this cycle
        send      = pending_q & credit_avail;
        pending_d = pending_q & ~send;
        // The next head is taken as soon as the last copy leaves
        if (pending_d == '0) begin
          state_d = FORK_IDLE;
          load    = head_valid_i;
        end
      end
      default: begin
        state_d = FORK_IDLE;
      end
    endcase

    // A flit that reaches no port here is popped and dropped
    if (load) begin
      pending_d = route_sel_i;
      state_d   = (route_sel_i != '0) ? FORK_SEND : FORK_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= FORK_IDLE;
      pending_q <= '0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      flit_q <= head_flit_i;
    end
  end

  assign pop_o   = load;
  assign valid_o = send;
  assign flit_o  = flit_q;

  // ----------------------------------------------------------------------
  // Credit counters
  // ----------------------------------------------------------------------

  always_comb begin
    for (int unsigned r = 0; r < NumRoutes; r++) begin
      credit_avail[r] = (cnt_q[r] != '0);
      // A returned credit and a send in the same cycle cancel out
      unique case ({send[r], credit_i[r]})
        2'b10:   cnt_d[r] = cnt_q[r] - 1'b1;
        2'b01:   cnt_d[r] = cnt_q[r] + 1'b1;
        default: cnt_d[r] = cnt_q[r];
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= {NumRoutes{credit_cnt_t'(MaxCredits)}};
    end else begin
      cnt_q <= cnt_d;
    end
  end

  for (genvar r = 0; r < NumRoutes; r++) begin : gen_port_checks
    // The receiver returns at most as many credits as copies it was sent
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (credit_i[r] && !valid_o[r]) |-> (cnt_q[r] < credit_cnt_t'(MaxCredits)))
      else $error("credit counter of port %0d overflows", r);
  end

endmodule

`default_nettype wire

// File: logic/floo_mcast_node.sv
// Top level of the multicast fork stage joining input buffer, route mask and fork for one input link
`default_nettype none

module floo_mcast_node #(
  // Input buffer entries up to 15
  parameter int unsigned BufDepth   = 4,
  // Credits per output port up to 15
  parameter int unsigned MaxCredits = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // Position of this router in the mesh
  input  floo_mcast_pkg::xy_id_t      xy_id_i,
  // Input link under credit flow control
  input  logic                        valid_i,
  input  floo_mcast_pkg::flit_t       flit_i,
  output logic                        credit_o,
  // Output links with one bit per route_dir_e
  output floo_mcast_pkg::route_mask_t valid_o,
  output floo_mcast_pkg::flit_t       flit_o,
  input  floo_mcast_pkg::route_mask_t credit_i
);

  import floo_mcast_pkg::*;

  // Head of the input buffer and the ports it has to reach
  logic        head_valid;
  flit_t       head_flit;
  route_mask_t route_sel;
  logic        pop;

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------

  floo_mcast_in_buffer #(
    .BufDepth (BufDepth)
  ) i_in_buffer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (valid_i),
    .flit_i       (flit_i),
    .credit_o     (credit_o),
    .head_valid_o (head_valid),
    .head_flit_o  (head_flit),
    .pop_i        (pop)
  );

  // The mask is formed from the head directly so it is ready when the fork loads
  floo_route_xymask i_route_xymask (
    .flit_i      (head_flit),
    .xy_id_i     (xy_id_i),
    .route_sel_o (route_sel)
  );

  floo_mcast_fork #(
    .MaxCredits (MaxCredits)
  ) i_fork (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .head_valid_i (head_valid),
    .head_flit_i  (head_flit),
    .route_sel_i  (route_sel),
    .pop_o        (pop),
    .valid_o      (valid_o),
    .flit_o       (flit_o),
    .credit_i     (credit_i)
  );

endmodule

`default_nettype wire

// File: verification/floo_mcast_tb.sv
// Self-checking testbench of the multicast fork node, compiled from verilog.f and run by run.sh
`default_nettype none

module floo_mcast_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import floo_mcast_pkg::*;

  localparam int BufDepth   = 4;
  localparam int MaxCredits = 2;
  localparam int RstCycles  = 8;
  // Unicast, directed multicasts, random headers and the stall test
  localparam int NumFlits   = 1 + 6 + 300 + 4;
  localparam xy_id_t MyId   = '{x: 3'd3, y: 3'd3};

  logic        clk = 1'b0;
  logic        rst_n;
  logic        in_valid;
  flit_t       in_flit;
  logic        in_credit;
  route_mask_t out_valid;
  flit_t       out_flit;
  route_mask_t out_credit;

  // Scoreboard with one queue of expected flits per port and one of masks
  flit_t       exp_q [NumRoutes][$];
  route_mask_t exp_mask_q [$];
  route_mask_t acc_mask = '0;

  // Receiver model in which each entry is the cycle where a credit may return
  int          owed [NumRoutes][$];
  int          ret_delay [NumRoutes];
  route_mask_t stall;
  route_mask_t credit_next = '0;

  int    cyc = 0;
  int    seed = 89;
  int    sent_cnt = 0;
  int    credit_cnt = 0;
  int    flit_errs = 0;
  int    mask_errs = 0;
  int    count_errs = 0;
  int    proto_errs = 0;
  string test_name = "reset";

  always #4 clk = ~clk;

  floo_mcast_node #(
    .BufDepth   (BufDepth),
    .MaxCredits (MaxCredits)
  ) i_floo_mcast_node (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .xy_id_i  (MyId),
    .valid_i  (in_valid),
    .flit_i   (in_flit),
    .credit_o (in_credit),
    .valid_o  (out_valid),
    .flit_o   (out_flit),
    .credit_i (out_credit)
  );

  // ----------------------------------------------------------------------
  // Reference model and compare tasks
  // ----------------------------------------------------------------------

  // Walks every coordinate of the destination set to find its reach
  function automatic route_mask_t route_ref(input flit_t f, input xy_id_t id);
    route_mask_t m;
    int          xmin, xmax, ymin, ymax;
    int          myx, myy, sx, sy;
    bit          xin, yin;
    m = '0;
    xmin = 8;
    xmax = -1;
    ymin = 8;
    ymax = -1;
    xin = 1'b0;
    yin = 1'b0;
    myx = int'(id.x);
    myy = int'(id.y);
    sx = int'(f.hdr.src_id.x);
    sy = int'(f.hdr.src_id.y);
    for (int v = 0; v < 8; v++) begin
      if (((x_coord_t'(v) ^ f.hdr.dst_id.x) & ~f.hdr.mask.x) == 3'b000) begin
        if (v < xmin) xmin = v;
        if (v > xmax) xmax = v;
        if (v == myx) xin = 1'b1;
      end
      if (((y_coord_t'(v) ^ f.hdr.dst_id.y) & ~f.hdr.mask.y) == 3'b000) begin
        if (v < ymin) ymin = v;
        if (v > ymax) ymax = v;
        if (v == myy) yin = 1'b1;
      end
    end
    m[Eject] = xin && yin;
    // Row spreading only happens in the row where the flit entered the mesh
    m[East]  = (myy == sy) && (myx >= sx) && (myx < xmax);
    m[West]  = (myy == sy) && (myx <= sx) && (myx > xmin);
    m[North] = xin && (myy >= sy) && (myy < ymax);
    m[South] = xin && (myy <= sy) && (myy > ymin);
    return m;
  endfunction

  function automatic flit_t make_flit(input int sx, sy, dx, dy, mx, my, input payload_t data);
    flit_t f;
    f.hdr.src_id.x = x_coord_t'(sx);
    f.hdr.src_id.y = y_coord_t'(sy);
    f.hdr.dst_id.x = x_coord_t'(dx);
    f.hdr.dst_id.y = y_coord_t'(dy);
    f.hdr.mask.x   = x_coord_t'(mx);
    f.hdr.mask.y   = y_coord_t'(my);
    f.payload      = data;
    return f;
  endfunction

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (exp !== act) begin
      $display("error %s flit expected %h actual %h", name, exp, act);
      flit_errs++;
    end
  endtask

  task automatic check_mask(input string name, input route_mask_t exp, input route_mask_t act);
    if (exp !== act) begin
      $display("error %s mask expected %b actual %b", name, exp, act);
      mask_errs++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("error %s count expected %0d actual %0d", name, exp, act);
      count_errs++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Monitor, scoreboard and receiver model
  // ----------------------------------------------------------------------

  // Outputs only change after a rising edge, so the falling edge sees them settled
  always @(negedge clk) begin
    flit_t exp_f;
    cyc++;
    credit_next = '0;
    if (!rst_n) begin
      if ((out_valid != '0) || in_credit) begin
        $display("outputs not low during reset (valid_o %b, credit_o %b)", out_valid, in_credit);
        proto_errs++;
      end
    end else begin
      if (in_credit) begin
        credit_cnt++;
        if (credit_cnt > sent_cnt) begin
          $display("credit_o pulsed without a flit outstanding in test %s", test_name);
          proto_errs++;
        end
      end
      for (int r = 0; r < NumRoutes; r++) begin
        if (out_valid[r]) begin
          if (exp_q[r].size() == 0) begin
            $display("unexpected flit on port %0d in test %s", r, test_name);
            proto_errs++;
          end else begin
            exp_f = exp_q[r].pop_front();
            check_flit(test_name, exp_f, out_flit);
          end
          owed[r].push_back(cyc + ret_delay[r]);
          if (owed[r].size() > MaxCredits) begin
            $display("port %0d holds more than %0d unanswered flits", r, MaxCredits);
            proto_errs++;
          end
        end
        // One credit per port and cycle, withheld while the port is stalled
        if (!stall[r] && (owed[r].size() != 0) && (owed[r][0] <= cyc)) begin
          credit_next[r] = 1'b1;
          void'(owed[r].pop_front());
        end
      end
      // All copies in one cycle belong to the same flit
      if (out_valid != '0) begin
        if (exp_mask_q.size() == 0) begin
          acc_mask = '0;
        end else begin
          acc_mask = acc_mask | out_valid;
          if ((acc_mask == exp_mask_q[0]) || ((acc_mask & ~exp_mask_q[0]) != '0)) begin
            check_mask(test_name, exp_mask_q.pop_front(), acc_mask);
            acc_mask = '0;
          end
        end
      end
    end
  end

  initial begin
    out_credit = '0;
    forever begin
      @(posedge clk);
      #1;
      out_credit = credit_next;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  // Called 1 ns after a rising edge and returns at the same point of a later cycle
  task automatic send_flit(input flit_t f);
    route_mask_t m;
    m = route_ref(f, MyId);
    while (sent_cnt - credit_cnt >= BufDepth) begin
      @(posedge clk);
      #1;
    end
    in_valid = 1'b1;
    in_flit  = f;
    sent_cnt++;
    for (int r = 0; r < NumRoutes; r++) begin
      if (m[r]) exp_q[r].push_back(f);
    end
    if (m != '0) exp_mask_q.push_back(m);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = (exp_mask_q.size() != 0);
      for (int r = 0; r < NumRoutes; r++) begin
        if ((exp_q[r].size() != 0) || (owed[r].size() != 0)) busy = 1'b1;
      end
    end
    repeat (10) @(posedge clk);
    #1;
  endtask

  initial begin
    route_mask_t exp_m;
    logic [31:0] rnd;
    flit_t       f;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_flit  = '0;
    stall    = '0;
    for (int r = 0; r < NumRoutes; r++) ret_delay[r] = 0;
    repeat (RstCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    #1;

    // Unicast to this router is ejected two cycles after it enters
    test_name = "unicast";
    exp_m = '0;
    exp_m[Eject] = 1'b1;
    send_flit(make_flit(0, 3, 3, 3, 0, 0, 32'h1111_0001));
    @(posedge clk);
    @(negedge clk);
    check_mask("unicast latency", exp_m, out_valid);
    @(posedge clk);
    #1;
    wait_drain();

    // Row and column multicasts plus one flit off the tree, with slow receivers
    test_name = "multicast";
    ret_delay = '{0, 3, 1, 5, 2};
    send_flit(make_flit(0, 3, 4, 3, 3, 0, 32'h2222_0001));
    send_flit(make_flit(6, 3, 0, 3, 3, 0, 32'h2222_0002));
    send_flit(make_flit(3, 1, 3, 4, 0, 3, 32'h2222_0003));
    send_flit(make_flit(3, 6, 3, 0, 0, 3, 32'h2222_0004));
    send_flit(make_flit(0, 5, 1, 5, 0, 0, 32'h2222_0005));
    send_flit(make_flit(3, 3, 0, 0, 7, 7, 32'h2222_0006));
    wait_drain();

    // Random headers with half of them injected in this router's row
    test_name = "random";
    ret_delay = '{0, 0, 0, 0, 0};
    repeat (300) begin
      rnd = $random(seed);
      f.hdr.dst_id = rnd[5:0];
      f.hdr.src_id = rnd[11:6];
      f.hdr.mask   = rnd[17:12] & rnd[24:19];
      if (rnd[18]) f.hdr.src_id.y = 3'd3;
      f.payload = $random(seed);
      send_flit(f);
    end
    wait_drain();

    // East gets no credits back, so only MaxCredits copies may leave on it
    test_name = "stall";
    stall[East] = 1'b1;
    for (int i = 0; i < 4; i++) begin
      send_flit(make_flit(0, 3, 3, 3, 4, 0, 32'h4444_0000 + i));
    end
    repeat (30) @(posedge clk);
    #1;
    check_count("stall east backlog", 4 - MaxCredits, exp_q[East].size());
    check_count("stall eject backlog", 4 - MaxCredits - 1, exp_q[Eject].size());
    stall[East] = 1'b0;
    wait_drain();

    check_count("credit_o pulses", sent_cnt, credit_cnt);

    $display("flit errors %0d, mask errors %0d, count errors %0d, protocol errors %0d",
             flit_errs, mask_errs, count_errs, proto_errs);
    if ((flit_errs + mask_errs + count_errs + proto_errs) == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Generous bound of 200 cycles per flit on top of the reset time
  initial begin
    repeat (RstCycles + 200 * NumFlits) @(posedge clk);
    $display("watchdog expired in test %s, the DUT stopped delivering flits", test_name);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
logic/floo_mcast_pkg.sv
logic/floo_mcast_in_buffer.sv
logic/floo_route_xymask.sv
logic/floo_mcast_fork.sv
logic/floo_mcast_node.sv
verification/floo_mcast_tb.sv

// File: run.sh
#!/bin/sh
# Builds the multicast fork stage testbench with Verilator and runs it.
# The exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=floo_mcast_sim

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module floo_mcast_tb \
  -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1
